//--- hdl/pdp_bus_pkg.sv
// shared widths, address map and bus types for the PDP-11 style bus
// 22-bit physical addressing only, the I/O page is the top 8 KB
// RAM is fitted below 760000 octal, everything above up to the I/O page
// is absent memory and answers with a bus error
// register addresses are full 22-bit physical addresses in octal
`default_nettype none

package pdp_bus_pkg;

   // physical address and data word widths
   localparam int addr_w = 22;
   localparam int data_w = 16;

   // address bits 21..13 all ones select the I/O page
   localparam logic [8:0] iopage_tag = 9'o777;

   // first address with no RAM behind it
   localparam logic [addr_w-1:0] ram_top = 22'o760000;

   // console switch / display register
   localparam logic [addr_w-1:0] reg_switch = 22'o17777570;
   // processor status word window
   localparam logic [addr_w-1:0] reg_psw = 22'o17777776;

   // block fill DMA register window
   localparam logic [addr_w-1:0] reg_dma_addr = 22'o17777500;
   localparam logic [addr_w-1:0] reg_dma_count = 22'o17777502;
   localparam logic [addr_w-1:0] reg_dma_data = 22'o17777504;
   localparam logic [addr_w-1:0] reg_dma_ctl = 22'o17777506;

   // one bus request, used by the CPU, the DMA engine and the RAM port
   typedef struct packed {
      logic [addr_w-1:0] addr;
      logic [data_w-1:0] wdata;
      logic rd;
      logic wr;
      logic byte_op;
   } bus_req_t;

   // address class of the current CPU request
   typedef struct packed {
      logic is_iopage;
      logic is_ram;
      logic ram_absent;
   } decode_t;

   // bus grant states
   typedef enum logic [2:0] {
      g_idle,
      g_cpu,
      g_dma_start,
      g_dma_run
   } grant_t;

endpackage

`default_nettype wire

//--- hdl/bus_decode.sv
// address classifier for CPU requests
// purely combinational, the only place that knows the address map
// an I/O page hit never counts as RAM, so ram_absent only covers
// the hole between ram_top and the start of the I/O page
`timescale 1ns/1ps
`default_nettype none

module bus_decode
(
   input  pdp_bus_pkg::bus_req_t req,
   output pdp_bus_pkg::decode_t  dec
);

   // 22-bit map, octal
   //   00000000 - 00757777   fitted RAM
   //   00760000 - 17757777   no memory
   //   17760000 - 17777777   I/O page
   logic iopage_hit;
   logic below_top;

   // top nine address bits all set
   assign iopage_hit = (req.addr[21:13] == pdp_bus_pkg::iopage_tag);

   assign below_top = (req.addr < pdp_bus_pkg::ram_top);

   always_comb
   begin
      dec.is_iopage = iopage_hit;
      dec.is_ram = ~iopage_hit;
      // RAM space but nothing fitted there
      dec.ram_absent = ~iopage_hit & ~below_top;
   end

endmodule

`default_nettype wire

//--- hdl/bus_arbiter.sv
// grant FSM sharing the single RAM port between the CPU and one DMA device
// DMA wins from idle when bus_arbitrate allows it, one word per grant
// CPU I/O page and absent memory cycles end in the first granted cycle,
// RAM cycles end on ram_done; bus_error is only meaningful with bus_ack
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter
(
   input  logic                  clk,
   input  logic                  reset,
   input  pdp_bus_pkg::bus_req_t cpu_req,
   input  pdp_bus_pkg::decode_t  dec,
   input  logic                  bus_arbitrate,
   input  logic                  dma_req,
   input  pdp_bus_pkg::bus_req_t dma_mem,
   input  logic                  ram_done,
   input  logic                  no_decode,
   output pdp_bus_pkg::bus_req_t ram_req,
   output logic                  bus_ack,
   output logic                  bus_error,
   output logic                  dma_ack,
   output logic                  iopage_rd,
   output logic                  iopage_wr
);

   pdp_bus_pkg::grant_t state;
   pdp_bus_pkg::grant_t state_next;

   logic cpu_active;
   logic cpu_ram;
   logic cpu_done;
   logic grant_cpu;
   logic grant_dma;

   assign cpu_active = cpu_req.rd | cpu_req.wr;
   // fitted RAM only, absent memory never reaches the RAM pins
   assign cpu_ram = dec.is_ram & ~dec.ram_absent;
   assign cpu_done = ~cpu_ram | ram_done;

   assign grant_cpu = (state == pdp_bus_pkg::g_cpu);
   assign grant_dma = (state == pdp_bus_pkg::g_dma_run);

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= pdp_bus_pkg::g_idle;
      else
         state <= state_next;
   end

   always_comb
   begin
      state_next = state;
      case (state)
         pdp_bus_pkg::g_idle:
         begin
            if (dma_req && bus_arbitrate)
               state_next = pdp_bus_pkg::g_dma_start;
            else if (cpu_active)
               state_next = pdp_bus_pkg::g_cpu;
         end
         pdp_bus_pkg::g_cpu:
         begin
            // a dropped request also frees the bus
            if (!cpu_active || cpu_done)
               state_next = pdp_bus_pkg::g_idle;
         end
         pdp_bus_pkg::g_dma_start:
            state_next = pdp_bus_pkg::g_dma_run;
         pdp_bus_pkg::g_dma_run:
         begin
            if (ram_done)
               state_next = pdp_bus_pkg::g_idle;
         end
         default:
            state_next = pdp_bus_pkg::g_idle;
      endcase
   end

   // RAM port mux, strobes only while the owner holds the grant
   always_comb
   begin
      if (state == pdp_bus_pkg::g_dma_start || grant_dma)
      begin
         ram_req = dma_mem;
         ram_req.rd = grant_dma & dma_mem.rd;
         ram_req.wr = grant_dma & dma_mem.wr;
      end
      else
      begin
         ram_req = cpu_req;
         ram_req.rd = grant_cpu & cpu_ram & cpu_req.rd;
         ram_req.wr = grant_cpu & cpu_ram & cpu_req.wr;
      end
   end

   assign iopage_rd = grant_cpu & cpu_req.rd & dec.is_iopage;
   assign iopage_wr = grant_cpu & cpu_req.wr & dec.is_iopage;

   assign bus_ack = grant_cpu & cpu_active & cpu_done;
   assign bus_error = bus_ack & (dec.ram_absent | (dec.is_iopage & no_decode));

   assign dma_ack = grant_dma & ram_done;

   // the RAM port owner keeps strobe, address and data until ram_done
   a_ram_hold: assert property (@(posedge clk) disable iff (reset)
      (ram_req.rd || ram_req.wr) && !ram_done |=> $stable(ram_req));

   a_ram_strobes: assert property (@(posedge clk) disable iff (reset)
      !(ram_req.rd && ram_req.wr));

   // a DMA word is only acknowledged once it is on the RAM pins
   a_dma_ack_strobe: assert property (@(posedge clk) disable iff (reset)
      dma_ack |-> ram_req.rd || ram_req.wr);

endmodule

`default_nettype wire

//--- hdl/iopage_regs.sv
// I/O page registers: switches/display, PSW window and the DMA fill window
// whole words only, byte writes update the full register
// DMA start address is word aligned and limited to the low 64 KB
// any other I/O page address raises no_decode during the access
`timescale 1ns/1ps
`default_nettype none

module iopage_regs
(
   input  logic        clk,
   input  logic        reset,
   input  logic [21:0] addr,
   input  logic [15:0] wdata,
   input  logic        iopage_rd,
   input  logic        iopage_wr,
   input  logic [15:0] switches,
   input  logic [15:0] psw,
   input  logic        dma_busy,
   output logic [15:0] rdata,
   output logic        no_decode,
   output logic [15:0] display,
   output logic        psw_io_wr,
   output logic        dma_start,
   output logic [21:0] start_addr,
   output logic [15:0] word_count,
   output logic [15:0] fill_data
);

   logic sel_switch;
   logic sel_psw;
   logic sel_dma_addr;
   logic sel_dma_count;
   logic sel_dma_data;
   logic sel_dma_ctl;
   logic hit;
   logic [15:0] dma_addr_reg;

   assign sel_switch = (addr == pdp_bus_pkg::reg_switch);
   assign sel_psw = (addr == pdp_bus_pkg::reg_psw);
   assign sel_dma_addr = (addr == pdp_bus_pkg::reg_dma_addr);
   assign sel_dma_count = (addr == pdp_bus_pkg::reg_dma_count);
   assign sel_dma_data = (addr == pdp_bus_pkg::reg_dma_data);
   assign sel_dma_ctl = (addr == pdp_bus_pkg::reg_dma_ctl);

   assign hit = sel_switch | sel_psw | sel_dma_addr | sel_dma_count |
                sel_dma_data | sel_dma_ctl;

   assign no_decode = (iopage_rd | iopage_wr) & ~hit;

   // control reads back done in bit 7, busy in bit 0
   always_comb
   begin
      rdata = 16'd0;
      if (sel_switch)
         rdata = switches;
      else if (sel_psw)
         rdata = psw;
      else if (sel_dma_addr)
         rdata = dma_addr_reg;
      else if (sel_dma_count)
         rdata = word_count;
      else if (sel_dma_data)
         rdata = fill_data;
      else if (sel_dma_ctl)
         rdata = {8'd0, ~dma_busy, 6'd0, dma_busy};
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         display <= 16'd0;
         psw_io_wr <= 1'b0;
         dma_start <= 1'b0;
      end
      else
      begin
         psw_io_wr <= iopage_wr & sel_psw;
         dma_start <= iopage_wr & sel_dma_ctl & wdata[0];
         if (iopage_wr && sel_switch)
            display <= wdata;
      end
   end

   // DMA parameters
   always_ff @(posedge clk)
   begin
      if (iopage_wr && sel_dma_addr)
         dma_addr_reg <= {wdata[15:1], 1'b0};
      if (iopage_wr && sel_dma_count)
         word_count <= wdata;
      if (iopage_wr && sel_dma_data)
         fill_data <= wdata;
   end

   assign start_addr = {6'd0, dma_addr_reg};

endmodule

`default_nettype wire

//--- hdl/dma_fill.sv
// block fill DMA engine, writes count words of an incrementing pattern
// word n goes to start_addr + 2n with value fill_data + n (mod 2^16)
// one word per dma_ack, a start while busy or with count zero is ignored
// the request drops for one cycle after each word so a waiting CPU gets the bus
`timescale 1ns/1ps
`default_nettype none

module dma_fill
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  dma_start,
   input  logic [21:0]           start_addr,
   input  logic [15:0]           word_count,
   input  logic [15:0]           fill_data,
   input  logic                  dma_ack,
   output logic                  dma_req,
   output pdp_bus_pkg::bus_req_t dma_mem,
   output logic                  dma_busy
);

   logic busy;
   logic ack_gap;
   logic [21:0] cur_addr;
   logic [15:0] remaining;
   logic [15:0] cur_val;
   logic accept;
   logic last_word;

   assign accept = dma_start & ~busy & (word_count != 16'd0);
   assign last_word = (remaining == 16'd1);

   always_ff @(posedge clk)
   begin
      if (reset)
         busy <= 1'b0;
      else if (accept)
         busy <= 1'b1;
      else if (dma_ack && last_word)
         busy <= 1'b0;
   end

   // free cycle after each word
   always_ff @(posedge clk)
   begin
      if (reset)
         ack_gap <= 1'b0;
      else
         ack_gap <= dma_ack;
   end

   // address, value and count of the word in flight
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         cur_addr <= start_addr;
         remaining <= word_count;
         cur_val <= fill_data;
      end
      else if (dma_ack)
      begin
         cur_addr <= cur_addr + 22'd2;
         remaining <= remaining - 16'd1;
         cur_val <= cur_val + 16'd1;
      end
   end

   // request is a level for as long as words remain
   assign dma_req = busy & ~ack_gap;
   assign dma_busy = busy;

   always_comb
   begin
      dma_mem.addr = cur_addr;
      dma_mem.wdata = cur_val;
      dma_mem.rd = 1'b0;
      dma_mem.wr = busy;
      dma_mem.byte_op = 1'b0;
   end

   // the arbiter only acknowledges a word that is requested
   a_ack_requested: assert property (@(posedge clk) disable iff (reset)
      dma_ack |-> dma_req);

endmodule

`default_nettype wire

//--- hdl/bus_top.sv
// bus side of a small PDP-11 style system, CPU port plus one RAM port
// the CPU holds its request until bus_ack; the RAM holds nothing,
// it answers a held strobe with a one cycle ram_done
// DMA traffic only runs while bus_arbitrate is high
`timescale 1ns/1ps
`default_nettype none

module bus_top
(
   input  logic        clk,
   input  logic        reset,
   // CPU side
   input  logic        bus_rd,
   input  logic        bus_wr,
   input  logic        bus_byte_op,
   input  logic [21:0] bus_addr,
   input  logic [15:0] bus_data_in,
   input  logic        bus_arbitrate,
   output logic [15:0] bus_data_out,
   output logic        bus_ack,
   output logic        bus_error,
   // RAM side
   output logic [21:0] ram_addr,
   output logic [15:0] ram_data_out,
   output logic        ram_rd,
   output logic        ram_wr,
   output logic        ram_byte_op,
   input  logic [15:0] ram_data_in,
   input  logic        ram_done,
   // console and PSW
   input  logic [15:0] switches,
   output logic [15:0] display,
   input  logic [15:0] psw,
   output logic        psw_io_wr
);

   pdp_bus_pkg::bus_req_t cpu_req;
   pdp_bus_pkg::bus_req_t ram_req;
   pdp_bus_pkg::bus_req_t dma_mem;
   pdp_bus_pkg::decode_t dec;

   logic iopage_rd;
   logic iopage_wr;
   logic [15:0] io_rdata;
   logic no_decode;
   logic dma_start;
   logic [21:0] start_addr;
   logic [15:0] word_count;
   logic [15:0] fill_data;
   logic dma_busy;
   logic dma_req;
   logic dma_ack;

   always_comb
   begin
      cpu_req.addr = bus_addr;
      cpu_req.wdata = bus_data_in;
      cpu_req.rd = bus_rd;
      cpu_req.wr = bus_wr;
      cpu_req.byte_op = bus_byte_op;
   end

   bus_decode bus_decode_i
   (
      .req (cpu_req),
      .dec (dec)
   );

   bus_arbiter bus_arbiter_i
   (
      .clk           (clk),
      .reset         (reset),
      .cpu_req       (cpu_req),
      .dec           (dec),
      .bus_arbitrate (bus_arbitrate),
      .dma_req       (dma_req),
      .dma_mem       (dma_mem),
      .ram_done      (ram_done),
      .no_decode     (no_decode),
      .ram_req       (ram_req),
      .bus_ack       (bus_ack),
      .bus_error     (bus_error),
      .dma_ack       (dma_ack),
      .iopage_rd     (iopage_rd),
      .iopage_wr     (iopage_wr)
   );

   iopage_regs iopage_regs_i
   (
      .clk        (clk),
      .reset      (reset),
      .addr       (cpu_req.addr),
      .wdata      (cpu_req.wdata),
      .iopage_rd  (iopage_rd),
      .iopage_wr  (iopage_wr),
      .switches   (switches),
      .psw        (psw),
      .dma_busy   (dma_busy),
      .rdata      (io_rdata),
      .no_decode  (no_decode),
      .display    (display),
      .psw_io_wr  (psw_io_wr),
      .dma_start  (dma_start),
      .start_addr (start_addr),
      .word_count (word_count),
      .fill_data  (fill_data)
   );

   dma_fill dma_fill_i
   (
      .clk        (clk),
      .reset      (reset),
      .dma_start  (dma_start),
      .start_addr (start_addr),
      .word_count (word_count),
      .fill_data  (fill_data),
      .dma_ack    (dma_ack),
      .dma_req    (dma_req),
      .dma_mem    (dma_mem),
      .dma_busy   (dma_busy)
   );

   // RAM pins
   assign ram_addr = ram_req.addr;
   assign ram_data_out = ram_req.wdata;
   assign ram_rd = ram_req.rd;
   assign ram_wr = ram_req.wr;
   assign ram_byte_op = ram_req.byte_op;

   assign bus_data_out = dec.is_iopage ? io_rdata : ram_data_in;

endmodule

`default_nettype wire

//--- bench/ram_model.sv
// behavioral RAM for the bus testbench, sparse, unwritten words read as zero
// one access at a time; a held strobe is answered after 1 to 4 cycles
// byte writes use the data lane of the addressed byte: even low, odd high
// write_count counts completed writes so a test can see untouched RAM
`timescale 1ns/1ps
`default_nettype none

module ram_model
(
   input  logic        clk,
   input  logic        reset,
   input  logic [21:0] addr,
   input  logic [15:0] wdata,
   input  logic        rd,
   input  logic        wr,
   input  logic        byte_op,
   output logic [15:0] rdata,
   output logic        done,
   output int          write_count
);

   logic [15:0] mem [int];
   int seed = 32'h33ac16d0;
   logic busy;
   int wait_left;
   int idx;
   logic [15:0] word;

   always @(posedge clk)
   begin
      if (reset)
      begin
         done <= 1'b0;
         busy <= 1'b0;
         rdata <= 16'h0000;
         write_count <= 0;
         wait_left <= 0;
      end
      else if (done)
         // strobes drop in the cycle after done
         done <= 1'b0;
      else if (!busy)
      begin
         if (rd || wr)
         begin
            busy <= 1'b1;
            wait_left <= 1 + int'($unsigned($random(seed)) % 4);
         end
      end
      else if (wait_left > 1)
         wait_left <= wait_left - 1;
      else
      begin
         busy <= 1'b0;
         done <= 1'b1;
         idx = int'(addr[21:1]);
         word = mem.exists(idx) ? mem[idx] : 16'h0000;
         if (wr)
         begin
            if (!byte_op)
               word = wdata;
            else if (addr[0])
               word[15:8] = wdata[15:8];
            else
               word[7:0] = wdata[7:0];
            mem[idx] = word;
            write_count <= write_count + 1;
         end
         else
            rdata <= word;
      end
   end

endmodule

`default_nettype wire

//--- bench/bus_tb.sv
// testbench for bus_top with a sparse RAM model behind the RAM port
// inputs change 2 ns after the rising edge, outputs are sampled on the falling edge
// the shadow RAM treats unwritten words as zero, like ram_model
// DMA blocks are kept in the low 64 KB, the reach of the DMA address register
`timescale 1ns/1ps
`default_nettype none

module bus_tb;

   logic clk = 1'b0;
   logic reset;
   logic bus_rd;
   logic bus_wr;
   logic bus_byte_op;
   logic [21:0] bus_addr;
   logic [15:0] bus_data_in;
   logic bus_arbitrate;
   logic [15:0] bus_data_out;
   logic bus_ack;
   logic bus_error;
   logic [21:0] ram_addr;
   logic [15:0] ram_data_out;
   logic ram_rd;
   logic ram_wr;
   logic ram_byte_op;
   logic [15:0] ram_data_in;
   logic ram_done;
   logic [15:0] switches;
   logic [15:0] display;
   logic [15:0] psw;
   logic psw_io_wr;

   int ram_writes;
   int seed = 32'h33ac16d0;
   int errors = 0;
   int checks = 0;
   int test_mark = 0;
   int psw_pulses = 0;
   int cycles = 0;
   logic [15:0] ref_mem [int];
   int known_words[$];

   always #10 clk = ~clk;

   always @(posedge clk)
      cycles <= cycles + 1;

   always @(negedge clk)
      if (psw_io_wr)
         psw_pulses <= psw_pulses + 1;

   bus_top bus_top_i
   (
      .clk (clk), .reset (reset),
      .bus_rd (bus_rd), .bus_wr (bus_wr), .bus_byte_op (bus_byte_op),
      .bus_addr (bus_addr), .bus_data_in (bus_data_in), .bus_arbitrate (bus_arbitrate),
      .bus_data_out (bus_data_out), .bus_ack (bus_ack), .bus_error (bus_error),
      .ram_addr (ram_addr), .ram_data_out (ram_data_out), .ram_rd (ram_rd),
      .ram_wr (ram_wr), .ram_byte_op (ram_byte_op), .ram_data_in (ram_data_in),
      .ram_done (ram_done), .switches (switches), .display (display),
      .psw (psw), .psw_io_wr (psw_io_wr)
   );

   ram_model ram_model_i
   (
      .clk (clk), .reset (reset), .addr (ram_addr), .wdata (ram_data_out),
      .rd (ram_rd), .wr (ram_wr), .byte_op (ram_byte_op), .rdata (ram_data_in),
      .done (ram_done), .write_count (ram_writes)
   );

   function automatic int unsigned urand(input int unsigned n);
      return $unsigned($random(seed)) % n;
   endfunction

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      checks++;
      if (expected !== actual)
      begin
         $display("** Error: %s expected %h actual %h", name, expected, actual);
         errors++;
      end
   endtask

   task automatic finish_test(input string name);
      $display("test %s finished with %0d errors", name, errors - test_mark);
      test_mark = errors;
   endtask

   task automatic idle(input int n);
      repeat (n) @(posedge clk);
      #2;
   endtask

   // one CPU bus cycle, entered and left 2 ns after a rising edge
   task automatic cpu_cycle(input logic write, input logic byte_op, input logic [21:0] addr,
                            input logic [15:0] data, output logic [15:0] rdata,
                            output logic err);
      int waited;
      logic acked;
      waited = 0;
      acked = 1'b0;
      rdata = 16'h0000;
      err = 1'b0;
      bus_addr = addr;
      bus_data_in = data;
      bus_byte_op = byte_op;
      bus_rd = !write;
      bus_wr = write;
      while (!acked && waited < 50)
      begin
         @(negedge clk);
         if (bus_ack)
         begin
            acked = 1'b1;
            rdata = bus_data_out;
            err = bus_error;
         end
         else
            waited++;
      end
      if (!acked)
      begin
         $display("no bus_ack within 50 cycles for address %o", addr);
         errors++;
      end
      @(posedge clk);
      #2;
      bus_rd = 1'b0;
      bus_wr = 1'b0;
      @(posedge clk);
      #2;
   endtask

   function automatic logic [15:0] ref_word(input int idx);
      if (ref_mem.exists(idx))
         return ref_mem[idx];
      return 16'h0000;
   endfunction

   // shadow write, byte lanes follow the PDP-11 convention
   task automatic ref_write(input logic [21:0] addr, input logic [15:0] data,
                            input logic byte_op);
      int idx;
      logic [15:0] w;
      idx = int'(addr[21:1]);
      w = ref_word(idx);
      if (!byte_op)
         w = data;
      else if (addr[0])
         w[15:8] = data[15:8];
      else
         w[7:0] = data[7:0];
      ref_mem[idx] = w;
   endtask

   task automatic ram_write(input string name, input logic [21:0] addr,
                            input logic [15:0] data, input logic byte_op);
      logic [15:0] rdata;
      logic err;
      cpu_cycle(1'b1, byte_op, addr, data, rdata, err);
      check({name, " bus_error"}, 0, err);
      ref_write(addr, data, byte_op);
      known_words.push_back(int'(addr[21:1]));
   endtask

   task automatic ram_read_check(input string name, input int idx);
      logic [15:0] rdata;
      logic err;
      cpu_cycle(1'b0, 1'b0, 22'(idx) << 1, 16'h0000, rdata, err);
      check({name, " bus_error"}, 0, err);
      check(name, ref_word(idx), rdata);
   endtask

   task automatic io_write(input string name, input logic [21:0] addr,
                           input logic [15:0] data);
      logic [15:0] rdata;
      logic err;
      cpu_cycle(1'b1, 1'b0, addr, data, rdata, err);
      check({name, " bus_error"}, 0, err);
   endtask

   task automatic program_dma(input logic [15:0] start, input logic [15:0] count,
                              input logic [15:0] fill);
      io_write("dma address", pdp_bus_pkg::reg_dma_addr, start);
      io_write("dma count", pdp_bus_pkg::reg_dma_count, count);
      io_write("dma data", pdp_bus_pkg::reg_dma_data, fill);
      io_write("dma control", pdp_bus_pkg::reg_dma_ctl, 16'h0001);
   endtask

   // poll the control register until done (bit 7)
   task automatic wait_dma_done(input string name);
      int polls;
      logic done;
      logic [15:0] rdata;
      logic err;
      polls = 0;
      done = 1'b0;
      while (!done && polls < 40)
      begin
         cpu_cycle(1'b0, 1'b0, pdp_bus_pkg::reg_dma_ctl, 16'h0000, rdata, err);
         done = rdata[7];
         polls++;
      end
      if (!done)
      begin
         $display("%s: DMA fill not done after %0d polls of the control register",
                  name, polls);
         errors++;
      end
      else
         check({name, " busy clear"}, 0, rdata[0]);
   endtask

   // word n at start + 2n holds fill + n
   task automatic verify_fill(input string name, input logic [15:0] start,
                              input int count, input logic [15:0] fill);
      int idx;
      logic [15:0] rdata;
      logic err;
      for (int n = 0; n < count; n++)
      begin
         idx = int'(start >> 1) + n;
         cpu_cycle(1'b0, 1'b0, 22'(idx) << 1, 16'h0000, rdata, err);
         check({name, " word"}, 16'(fill + 16'(n)), rdata);
         ref_mem[idx] = 16'(fill + 16'(n));
      end
      ram_read_check({name, " neighbour below"}, int'(start >> 1) - 1);
      ram_read_check({name, " neighbour above"}, int'(start >> 1) + count);
   endtask

   initial
   begin : main
      int ram_words;
      int span;
      int count;
      int writes_before;
      int pulses_before;
      int t0;
      int guard;
      logic [21:0] a;
      logic [15:0] d;
      logic [15:0] rdata;
      logic [15:0] start;
      logic [15:0] fill;
      logic err;

      reset = 1'b1;
      bus_rd = 1'b0;
      bus_wr = 1'b0;
      bus_byte_op = 1'b0;
      bus_addr = 22'd0;
      bus_data_in = 16'h0000;
      bus_arbitrate = 1'b1;
      switches = 16'h0000;
      psw = 16'h0000;
      repeat (4) @(posedge clk);
      #2;
      reset = 1'b0;
      idle(2);

      ram_words = int'(pdp_bus_pkg::ram_top >> 1);
      for (int i = 0; i < 24; i++)
      begin
         a = 22'(urand(ram_words)) << 1;
         d = 16'($random(seed));
         if (urand(2) == 1)
            ram_write("ram byte write", a | 22'(urand(2)), d, 1'b1);
         else
            ram_write("ram word write", a, d, 1'b0);
      end
      foreach (known_words[i])
         ram_read_check("ram read", known_words[i]);
      finish_test("ram");

      // hole between fitted RAM and the I/O page
      span = int'(22'o17760000 - pdp_bus_pkg::ram_top);
      writes_before = ram_writes;
      for (int i = 0; i < 8; i++)
      begin
         a = pdp_bus_pkg::ram_top + 22'(urand(span));
         cpu_cycle(1'b1, 1'b0, a, 16'($random(seed)), rdata, err);
         check("absent write bus_error", 1, err);
         cpu_cycle(1'b0, 1'b0, a, 16'h0000, rdata, err);
         check("absent read bus_error", 1, err);
      end
      check("absent ram writes", writes_before, ram_writes);
      finish_test("absent");

      switches = 16'($random(seed));
      cpu_cycle(1'b0, 1'b0, pdp_bus_pkg::reg_switch, 16'h0000, rdata, err);
      check("console switches", switches, rdata);
      check("console switches bus_error", 0, err);
      d = 16'($random(seed));
      io_write("console display", pdp_bus_pkg::reg_switch, d);
      check("console display", d, display);
      psw = 16'($random(seed));
      cpu_cycle(1'b0, 1'b0, pdp_bus_pkg::reg_psw, 16'h0000, rdata, err);
      check("psw read", psw, rdata);
      pulses_before = psw_pulses;
      io_write("psw write", pdp_bus_pkg::reg_psw, 16'($random(seed)));
      idle(4);
      check("psw_io_wr pulses", 1, psw_pulses - pulses_before);
      finish_test("console");

      for (int i = 0; i < 8; i++)
      begin
         guard = 0;
         a = 22'o17760000 | 22'(urand(8192));
         while (guard < 20 && (a == pdp_bus_pkg::reg_switch || a == pdp_bus_pkg::reg_psw ||
                a[21:3] == pdp_bus_pkg::reg_dma_addr[21:3]))
         begin
            a = 22'o17760000 | 22'(urand(8192));
            guard++;
         end
         cpu_cycle(1'b0, 1'b0, a, 16'h0000, rdata, err);
         check("unmapped read bus_error", 1, err);
         cpu_cycle(1'b1, 1'b0, a, 16'($random(seed)), rdata, err);
         check("unmapped write bus_error", 1, err);
      end
      finish_test("unmapped");

      start = 16'h0200 + 16'(urand(16'h7000) << 1);
      count = 1 + int'(urand(8));
      fill = 16'($random(seed));
      ram_write("dma neighbour", 22'(start) - 22'd2, 16'($random(seed)), 1'b0);
      ram_write("dma neighbour", 22'(start) + 22'(count * 2), 16'($random(seed)), 1'b0);
      program_dma(start, 16'(count), fill);
      wait_dma_done("dma");
      verify_fill("dma", start, count, fill);
      finish_test("dma");

      // DMA parked while bus_arbitrate is low
      bus_arbitrate = 1'b0;
      start = 16'h0200 + 16'(urand(16'h7000) << 1);
      count = 1 + int'(urand(8));
      fill = 16'($random(seed));
      ram_write("hold neighbour", 22'(start) - 22'd2, 16'($random(seed)), 1'b0);
      ram_write("hold neighbour", 22'(start) + 22'(count * 2), 16'($random(seed)), 1'b0);
      program_dma(start, 16'(count), fill);
      writes_before = ram_writes;
      t0 = cycles;
      guard = 0;
      while (cycles - t0 < 100 && guard < 100)
      begin
         ram_read_check("hold cpu read", known_words[urand(known_words.size())]);
         guard++;
      end
      cpu_cycle(1'b0, 1'b0, pdp_bus_pkg::reg_dma_ctl, 16'h0000, rdata, err);
      check("hold done bit", 0, rdata[7]);
      check("hold busy bit", 1, rdata[0]);
      check("hold ram writes", writes_before, ram_writes);
      bus_arbitrate = 1'b1;
      wait_dma_done("dma_hold");
      verify_fill("dma_hold", start, count, fill);
      finish_test("dma_hold");

      $display("tests finished: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- compile.f
hdl/pdp_bus_pkg.sv
hdl/bus_decode.sv
hdl/bus_arbiter.sv
hdl/iopage_regs.sv
hdl/dma_fill.sv
hdl/bus_top.sv
bench/ram_model.sv
bench/bus_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the bus testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module bus_tb \
   -f compile.f \
   -o Vbus_tb

./obj_dir/Vbus_tb | tee sim.log

if grep -q "^RESULT: PASS$" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
